/* store_path.f */
common/lsu_pkg.sv
common/mem_pkg.sv
hw/addr_translator.sv
hw/store_unit/store_queue.sv
hw/store_unit/store_unit.sv
hw/store_path_top.sv
sim/tb_store_path.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --assert -Wno-fatal
TOP      := tb_store_path
FILELIST := store_path.f

BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_store_path.sv */
// ----------------------------------------------------------
// store path testbench
// random stores against a queue model, a cache responder
// with random grants, checks completion, drain and flush
// ----------------------------------------------------------
module tb_store_path;
    import lsu_pkg::*;
    import mem_pkg::*;

    localparam int          SQ_DEPTH     = 4;
    localparam logic [63:0] PADDR_OFFSET = 64'h0000_0000_8000_0000;
    localparam logic [51:0] GUARD_BASE   = 52'h00000_000F0000;
    localparam int          NUM_STORES   = 400;
    // 400 stores at about 12 cycles each
    localparam int          MAX_CYCLES   = 5000;

    logic                     clk_i;
    logic                     reset_i;
    logic                     flush_i;
    store_req_t               store_req_i;
    logic                     valid_i;
    logic                     commit_i;
    logic                     ready_o;
    logic                     valid_o;
    logic [trans_id_bits-1:0] trans_id_o;
    exception_t               ex_o;
    logic                     no_st_pending_o;
    logic [11:0]              page_offset_i;
    logic                     page_offset_matches_o;
    logic                     data_req_o;
    dcache_wreq_t             dcache_wreq_o;
    logic                     data_gnt_i;

    // reference model, oldest entry first, committed ones in front
    dcache_wreq_t             exp_q[$];
    int                       spec_cnt;
    int                       commit_cnt;
    // translator result expected in the current cycle
    logic                     tv_model;
    // store held on the issue port
    logic                     held;
    logic                     pend_fault;
    logic [trans_id_bits-1:0] pend_id;
    dcache_wreq_t             pend_wr;
    int                       pend_edges;
    logic                     pend_room;
    logic [31:0]              lfsr_q;
    int                       cycle_cnt;
    int                       errors;
    int                       issued;
    int                       faults;
    int                       flushes;
    int                       writes;
    int                       stall_cycles;
    logic                     done;
    logic                     timed_out;

    store_path_top #(
        .SQ_DEPTH     (SQ_DEPTH),
        .PADDR_OFFSET (PADDR_OFFSET),
        .GUARD_BASE   (GUARD_BASE)
    ) u_store_path_top (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .flush_i               (flush_i),
        .store_req_i           (store_req_i),
        .valid_i               (valid_i),
        .commit_i              (commit_i),
        .ready_o               (ready_o),
        .valid_o               (valid_o),
        .trans_id_o            (trans_id_o),
        .ex_o                  (ex_o),
        .no_st_pending_o       (no_st_pending_o),
        .page_offset_i         (page_offset_i),
        .page_offset_matches_o (page_offset_matches_o),
        .data_req_o            (data_req_o),
        .dcache_wreq_o         (dcache_wreq_o),
        .data_gnt_i            (data_gnt_i)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    // ------------------------------------------------------------
    // random source, galois lfsr stepped once per bit
    // ------------------------------------------------------------
    function automatic logic lfsr_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr_bit()};
        end
        return r;
    endfunction

    // byte b of the source lands in lane b + offset, wrapping
    function automatic logic [63:0] rotate_to_lane(input logic [63:0] data,
                                                   input logic [2:0] lane);
        logic [63:0] r;
        for (int b = 0; b < 8; b++) begin
            r[((b + int'(lane)) % 8) * 8 +: 8] = data[b * 8 +: 8];
        end
        return r;
    endfunction

    task automatic mismatch(input string name, input logic [128:0] exp_v,
                            input logic [128:0] act_v);
        errors++;
        $display("Error %s: expected %0h actual %0h", name, exp_v, act_v);
    endtask

    // ------------------------------------------------------------
    // new store and its expected cache write
    // ------------------------------------------------------------
    task automatic present_store();
        logic        guard;
        logic [51:0] vpn;
        logic [63:0] paddr;
        logic [11:0] offset;
        logic [63:0] data;
        // about one in eight lands in the guard region
        guard = (rand_bits(3) == 0);
        if (guard) begin
            vpn = GUARD_BASE + 52'(rand_bits(8));
        end else begin
            vpn = 52'(rand_bits(19));
        end
        offset = 12'(rand_bits(12));
        data   = rand_bits(64);
        store_req_i.operator = fu_op'(2'(rand_bits(2)));
        store_req_i.trans_id = trans_id_bits'(issued);
        store_req_i.vaddr    = {vpn, offset};
        store_req_i.be       = 8'(rand_bits(8));
        store_req_i.data     = data;
        valid_i = 1'b1;
        // the offset is page granular, so the page offset passes through
        paddr = store_req_i.vaddr + PADDR_OFFSET;
        pend_wr.address_index = paddr[11:0];
        pend_wr.address_tag   = paddr[55:12];
        pend_wr.wdata         = rotate_to_lane(data, offset[2:0]);
        pend_wr.be            = store_req_i.be;
        pend_fault = guard;
        pend_id    = store_req_i.trans_id;
        pend_edges = 1;
        pend_room  = 1'b1;
        held       = 1'b1;
        issued++;
    endtask

    // inputs for the coming rising edge
    task automatic drive_cycle();
        flush_i  = 1'b0;
        commit_i = 1'b0;
        if (!held) begin
            valid_i = 1'b0;
            if (issued < NUM_STORES) begin
                if (rand_bits(2) != 0) begin
                    present_store();
                end else if (spec_cnt > 0 && rand_bits(4) == 0) begin
                    flush_i = 1'b1;
                    flushes++;
                end
            end
        end
        // drain phase commits everything left
        if (spec_cnt > 0 && (issued == NUM_STORES || rand_bits(1) != 0)) begin
            commit_i = 1'b1;
        end
        // grants withheld for a while so the queue fills up
        if (cycle_cnt >= 300 && cycle_cnt < 420) begin
            data_gnt_i = 1'b0;
        end else begin
            data_gnt_i = (rand_bits(1) != 0);
        end
        // half the time probe the oldest entry's doubleword
        if (exp_q.size() > 0 && rand_bits(1) != 0) begin
            page_offset_i = exp_q[0].address_index ^ 12'(rand_bits(3));
        end else begin
            page_offset_i = 12'(rand_bits(12));
        end
    endtask

    // ------------------------------------------------------------
    // compare outputs, then step the model past the rising edge
    // ------------------------------------------------------------
    task automatic check_cycle();
        logic room;
        logic exp_valid;
        logic exp_ready;
        logic exp_match;
        room      = (exp_q.size() < SQ_DEPTH);
        exp_valid = valid_i && tv_model && room;
        exp_ready = !valid_i || (tv_model && room);
        exp_match = (exp_q.size() > 0) &&
                    (page_offset_i[11:3] == exp_q[0].address_index[11:3]);
        if (valid_o !== exp_valid) mismatch("valid_o", 129'(exp_valid), 129'(valid_o));
        if (ready_o !== exp_ready) mismatch("ready_o", 129'(exp_ready), 129'(ready_o));
        if (no_st_pending_o !== (exp_q.size() == 0)) begin
            mismatch("no_st_pending_o", 129'(exp_q.size() == 0), 129'(no_st_pending_o));
        end
        if (page_offset_matches_o !== exp_match) begin
            mismatch("page_offset_matches_o", 129'(exp_match), 129'(page_offset_matches_o));
        end
        if (data_req_o !== (commit_cnt > 0)) begin
            mismatch("data_req_o", 129'(commit_cnt > 0), 129'(data_req_o));
        end
        if (valid_i && tv_model && !room) stall_cycles++;
        // granted write retires the oldest committed entry
        if (data_req_o && data_gnt_i && commit_cnt > 0) begin
            if (dcache_wreq_o.address_tag !== exp_q[0].address_tag) begin
                mismatch("write tag", 129'(exp_q[0].address_tag),
                         129'(dcache_wreq_o.address_tag));
            end
            if (dcache_wreq_o.address_index !== exp_q[0].address_index) begin
                mismatch("write index", 129'(exp_q[0].address_index),
                         129'(dcache_wreq_o.address_index));
            end
            if (dcache_wreq_o.wdata !== exp_q[0].wdata) begin
                mismatch("write data", 129'(exp_q[0].wdata), 129'(dcache_wreq_o.wdata));
            end
            if (dcache_wreq_o.be !== exp_q[0].be) begin
                mismatch("write be", 129'(exp_q[0].be), 129'(dcache_wreq_o.be));
            end
            void'(exp_q.pop_front());
            commit_cnt--;
            writes++;
        end
        if (valid_o) begin
            if (trans_id_o !== pend_id) mismatch("trans_id_o", 129'(pend_id), 129'(trans_id_o));
            if (ex_o.valid !== pend_fault) begin
                mismatch("ex valid", 129'(pend_fault), 129'(ex_o.valid));
            end
            if (pend_fault && ex_o.cause !== 64'd15) begin
                mismatch("ex cause", 129'(15), 129'(ex_o.cause));
            end
            if (pend_fault && ex_o.tval !== store_req_i.vaddr) begin
                mismatch("ex tval", 129'(store_req_i.vaddr), 129'(ex_o.tval));
            end
            // with room all along the store takes two edges
            if (pend_room && pend_edges != 2) mismatch("latency", 129'(2), 129'(pend_edges));
            if (pend_fault) begin
                faults++;
            end else if (!flush_i) begin
                exp_q.push_back(pend_wr);
                spec_cnt++;
            end
            held = 1'b0;
        end else if (held) begin
            pend_room = pend_room && room;
            pend_edges++;
        end
        if (commit_i) begin
            spec_cnt--;
            commit_cnt++;
        end
        // only committed stores survive a flush
        if (flush_i) begin
            while (exp_q.size() > commit_cnt) begin
                void'(exp_q.pop_back());
            end
            spec_cnt = 0;
        end
        // translator drops a request right after a result
        tv_model = valid_i && !tv_model;
    endtask

    initial begin
        reset_i       = 1'b1;
        flush_i       = 1'b0;
        store_req_i   = '0;
        valid_i       = 1'b0;
        commit_i      = 1'b0;
        page_offset_i = '0;
        data_gnt_i    = 1'b0;
        lfsr_q        = 32'd53;
        spec_cnt      = 0;
        commit_cnt    = 0;
        tv_model      = 1'b0;
        held          = 1'b0;
        cycle_cnt     = 0;
        errors        = 0;
        issued        = 0;
        faults        = 0;
        flushes       = 0;
        writes        = 0;
        stall_cycles  = 0;
        done          = 1'b0;
        timed_out     = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        #1;
        // idle state straight out of reset
        if (ready_o !== 1'b1) mismatch("reset ready_o", 129'(1), 129'(ready_o));
        if (valid_o !== 1'b0) mismatch("reset valid_o", 129'(0), 129'(valid_o));
        if (data_req_o !== 1'b0) mismatch("reset data_req_o", 129'(0), 129'(data_req_o));
        if (no_st_pending_o !== 1'b1) begin
            mismatch("reset no_st_pending_o", 129'(1), 129'(no_st_pending_o));
        end
        while (!done && !timed_out) begin
            @(negedge clk_i);
            cycle_cnt++;
            if (cycle_cnt > MAX_CYCLES) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: store path did not drain within %0d cycles", MAX_CYCLES);
            end else begin
                drive_cycle();
                #1;
                check_cycle();
                done = (issued == NUM_STORES) && !held && (exp_q.size() == 0);
            end
        end
        if (stall_cycles == 0) begin
            errors++;
            $display("queue never filled up while grants were withheld");
        end
        $display("stores %0d, faults %0d, flushes %0d, cache writes %0d, stalls %0d, errors %0d",
                 issued, faults, flushes, writes, stall_cycles, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* hw/store_path_top.sv */
// ----------------------------------------------------------
// store path top
// address translator and store unit joined, exposes issue,
// commit, load check and data cache ports
// ----------------------------------------------------------
module store_path_top #(
    parameter int          SQ_DEPTH     = 4,
    parameter logic [63:0] PADDR_OFFSET = 64'h0000_0000_8000_0000,
    parameter logic [51:0] GUARD_BASE   = 52'h00000_000F0000
) (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              flush_i,
    // issue side
    input  lsu_pkg::store_req_t               store_req_i,
    input  logic                              valid_i,
    input  logic                              commit_i,
    output logic                              ready_o,
    output logic                              valid_o,
    output logic [lsu_pkg::trans_id_bits-1:0] trans_id_o,
    output lsu_pkg::exception_t               ex_o,
    output logic                              no_st_pending_o,
    // load check
    input  logic [11:0]                       page_offset_i,
    output logic                              page_offset_matches_o,
    // data cache write port
    output logic                              data_req_o,
    output mem_pkg::dcache_wreq_t             dcache_wreq_o,
    input  logic                              data_gnt_i
);
    import lsu_pkg::*;

    // store unit to translator
    logic        translation_req;
    logic [63:0] vaddr;
    logic [63:0] paddr;
    logic        translation_valid;
    exception_t  ex;

    addr_translator #(
        .PADDR_OFFSET (PADDR_OFFSET),
        .GUARD_BASE   (GUARD_BASE)
    ) u_addr_translator (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .translation_req_i   (translation_req),
        .vaddr_i             (vaddr),
        .translation_valid_o (translation_valid),
        .paddr_o             (paddr),
        .ex_o                (ex)
    );

    store_unit #(
        .SQ_DEPTH (SQ_DEPTH)
    ) u_store_unit (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .flush_i               (flush_i),
        .store_req_i           (store_req_i),
        .valid_i               (valid_i),
        .commit_i              (commit_i),
        .ready_o               (ready_o),
        .valid_o               (valid_o),
        .trans_id_o            (trans_id_o),
        .ex_o                  (ex_o),
        .no_st_pending_o       (no_st_pending_o),
        .translation_req_o     (translation_req),
        .vaddr_o               (vaddr),
        .paddr_i               (paddr),
        .translation_valid_i   (translation_valid),
        .ex_i                  (ex),
        .page_offset_i         (page_offset_i),
        .page_offset_matches_o (page_offset_matches_o),
        .data_req_o            (data_req_o),
        .dcache_wreq_o         (dcache_wreq_o),
        .data_gnt_i            (data_gnt_i)
    );

endmodule

/* hw/store_unit/store_unit.sv */
// ----------------------------------------------------------
// store unit
// store control, data re-aligner and page offset checker
// wrapped around the store queue
// ----------------------------------------------------------
module store_unit #(
    parameter int SQ_DEPTH = 4
) (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                flush_i,
    // issue side
    input  lsu_pkg::store_req_t                 store_req_i,
    input  logic                                valid_i,
    input  logic                                commit_i,
    output logic                                ready_o,
    output logic                                valid_o,
    output logic [lsu_pkg::trans_id_bits-1:0]   trans_id_o,
    output lsu_pkg::exception_t                 ex_o,
    output logic                                no_st_pending_o,
    // address translation
    output logic                                translation_req_o,
    output logic [63:0]                         vaddr_o,
    input  logic [63:0]                         paddr_i,
    input  logic                                translation_valid_i,
    input  lsu_pkg::exception_t                 ex_i,
    // load side check
    input  logic [11:0]                         page_offset_i,
    output logic                                page_offset_matches_o,
    // data cache write port
    output logic                                data_req_o,
    output mem_pkg::dcache_wreq_t               dcache_wreq_o,
    input  logic                                data_gnt_i
);
    import lsu_pkg::*;

    logic        st_valid;
    logic        st_ready;
    logic [63:0] st_data;
    logic [5:0]  rot_bits;
    logic [63:0] head_paddr;
    logic        head_valid;

    assign vaddr_o = store_req_i.vaddr;

    // ------------------------------------------------------------
    // store control
    // ------------------------------------------------------------
    always_comb begin
        translation_req_o = valid_i;
        valid_o           = 1'b0;
        ready_o           = 1'b1;
        trans_id_o        = store_req_i.trans_id;
        ex_o              = '0;
        st_valid          = 1'b0;
        if (valid_i) begin
            // need a translation and a free slot, else stall
            if (translation_valid_i && st_ready) begin
                valid_o = 1'b1;
                ex_o    = ex_i;
                // faulting stores report back but never reach the queue
                st_valid = !ex_i.valid;
            end else begin
                ready_o = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // re-aligner
    // ------------------------------------------------------------
    // rotate left by the byte offset into the doubleword lane
    assign rot_bits = {store_req_i.vaddr[2:0], 3'b000};
    assign st_data  = (store_req_i.data << rot_bits) |
                      (store_req_i.data >> (7'd64 - {1'b0, rot_bits}));

    store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) u_store_queue (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .valid_i         (st_valid),
        .paddr_i         (paddr_i),
        .data_i          (st_data),
        .be_i            (store_req_i.be),
        .commit_i        (commit_i),
        .ready_o         (st_ready),
        .no_st_pending_o (no_st_pending_o),
        .head_paddr_o    (head_paddr),
        .head_valid_o    (head_valid),
        .data_req_o      (data_req_o),
        .dcache_wreq_o   (dcache_wreq_o),
        .data_gnt_i      (data_gnt_i)
    );

    // ------------------------------------------------------------
    // page offset checker
    // ------------------------------------------------------------
    // offset bits are untranslated, so the load can compare early
    assign page_offset_matches_o = head_valid &&
                                   (page_offset_i[11:3] == head_paddr[11:3]);

    // a stalled store stays on the issue port until it completes
    a_valid_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        !ready_o |=> valid_i && $stable(store_req_i));

endmodule

/* hw/store_unit/store_queue.sv */
// ----------------------------------------------------------
// store queue
// circular buffer of speculative and committed stores,
// committed entries drain in order to the data cache
// ----------------------------------------------------------
module store_queue #(
    parameter int SQ_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  flush_i,
    // write port from store control
    input  logic                  valid_i,
    input  logic [63:0]           paddr_i,
    input  logic [63:0]           data_i,
    input  logic [7:0]            be_i,
    input  logic                  commit_i,
    output logic                  ready_o,
    output logic                  no_st_pending_o,
    // oldest entry for the page offset check
    output logic [63:0]           head_paddr_o,
    output logic                  head_valid_o,
    // data cache write port
    output logic                  data_req_o,
    output mem_pkg::dcache_wreq_t dcache_wreq_o,
    input  logic                  data_gnt_i
);
    import mem_pkg::*;

    localparam int ptr_bits = $clog2(SQ_DEPTH);

    typedef struct packed {
        logic [63:0] paddr;
        logic [63:0] data;
        logic [7:0]  be;
    } sq_entry_t;

    sq_entry_t mem_q [SQ_DEPTH];

    // pointers carry one extra wrap bit
    logic [ptr_bits:0] read_ptr_q;
    logic [ptr_bits:0] commit_ptr_q;
    logic [ptr_bits:0] write_ptr_q;
    logic [ptr_bits:0] commit_ptr_d;
    logic [ptr_bits:0] total_cnt;
    logic [ptr_bits:0] commit_cnt;
    logic [ptr_bits:0] spec_cnt;
    logic              full;
    logic              retire;
    sq_entry_t         head;

    // ------------------------------------------------------------
    // occupancy
    // ------------------------------------------------------------
    assign total_cnt  = write_ptr_q - read_ptr_q;
    assign commit_cnt = commit_ptr_q - read_ptr_q;
    assign spec_cnt   = write_ptr_q - commit_ptr_q;
    assign full       = (total_cnt == (ptr_bits + 1)'(SQ_DEPTH));

    assign ready_o         = !full;
    assign no_st_pending_o = (total_cnt == '0);

    // commit of this cycle, flush falls back to it
    assign commit_ptr_d = commit_ptr_q + {{ptr_bits{1'b0}}, commit_i};

    // ------------------------------------------------------------
    // pointer update
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            read_ptr_q   <= '0;
            commit_ptr_q <= '0;
            write_ptr_q  <= '0;
        end else begin
            commit_ptr_q <= commit_ptr_d;
            // drop every speculative entry and the store in flight
            if (flush_i) begin
                write_ptr_q <= commit_ptr_d;
            end else if (valid_i) begin
                write_ptr_q <= write_ptr_q + 1'b1;
            end
            if (retire) begin
                read_ptr_q <= read_ptr_q + 1'b1;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            mem_q[write_ptr_q[ptr_bits-1:0]] <= '{paddr: paddr_i, data: data_i, be: be_i};
        end
    end

    // ------------------------------------------------------------
    // drain to the data cache
    // ------------------------------------------------------------
    assign head = mem_q[read_ptr_q[ptr_bits-1:0]];

    // only a committed head may leave
    assign data_req_o = (commit_cnt != '0);
    assign retire     = data_req_o && data_gnt_i;

    assign dcache_wreq_o.address_index = head.paddr[dc_index_bits-1:0];
    assign dcache_wreq_o.address_tag   = head.paddr[dc_index_bits+dc_tag_bits-1:dc_index_bits];
    assign dcache_wreq_o.wdata         = head.data;
    assign dcache_wreq_o.be            = head.be;

    assign head_paddr_o = head.paddr;
    assign head_valid_o = (total_cnt != '0);

    // commit pulses only arrive for stores already queued
    a_commit_has_spec: assert property (@(posedge clk_i) disable iff (reset_i)
        commit_i |-> (spec_cnt != '0));

    // store control must respect ready_o
    a_no_write_full: assert property (@(posedge clk_i) disable iff (reset_i)
        valid_i |-> !full);

endmodule

/* hw/addr_translator.sv */
// ----------------------------------------------------------
// address translator
// one cycle registered fixed offset map, pages at or above
// the guard base raise a store page fault
// ----------------------------------------------------------
module addr_translator #(
    parameter logic [63:0] PADDR_OFFSET = 64'h0000_0000_8000_0000,
    parameter logic [51:0] GUARD_BASE   = 52'h00000_000F0000
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                translation_req_i,
    input  logic [63:0]         vaddr_i,
    output logic                translation_valid_o,
    output logic [63:0]         paddr_o,
    output lsu_pkg::exception_t ex_o
);
    import lsu_pkg::*;
    import mem_pkg::*;

    logic [vpn_bits-1:0] vpn;
    logic                fault;
    logic                accept;
    logic                valid_q;
    logic [63:0]         paddr_q;
    exception_t          ex_q;

    assign vpn   = vaddr_i[63:page_offset_bits];
    assign fault = (vpn >= GUARD_BASE);
    // back to back requests are dropped so the result can retire first
    assign accept = translation_req_i && !valid_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    // result payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            // page number moves, page offset stays
            paddr_q  <= {vpn + PADDR_OFFSET[63:page_offset_bits],
                         vaddr_i[page_offset_bits-1:0]};
            ex_q.cause <= fault ? store_fault_cause : 64'd0;
            ex_q.tval  <= fault ? vaddr_i : 64'd0;
            ex_q.valid <= fault;
        end
    end

    assign translation_valid_o = valid_q;
    assign paddr_o             = paddr_q;
    assign ex_o                = ex_q;

    // a result answers last cycle's request for the address still presented
    a_valid_has_req: assert property (@(posedge clk_i) disable iff (reset_i)
        translation_valid_o |-> $past(translation_req_i) && (vaddr_i == $past(vaddr_i)));

endmodule

/* common/mem_pkg.sv */
// ----------------------------------------------------------
// memory package
// physical address split, data cache write request and the
// constants used by the address translator
// ----------------------------------------------------------
package mem_pkg;

    // low address bits that virtual and physical addresses share
    localparam int page_offset_bits = 12;

    // virtual page number width seen by the translator
    localparam int vpn_bits = 64 - page_offset_bits;

    // data cache address split, index is the page offset
    localparam int dc_index_bits = page_offset_bits;
    localparam int dc_tag_bits   = 44;

    // ------------------------------------------------------------
    // cache write port request
    // ------------------------------------------------------------
    typedef struct packed {
        logic [dc_index_bits-1:0] address_index;
        logic [dc_tag_bits-1:0]   address_tag;
        logic [63:0]              wdata;
        logic [7:0]               be;
    } dcache_wreq_t;

endpackage

/* common/lsu_pkg.sv */
// ----------------------------------------------------------
// lsu package
// store operators, exception record and the store request
// that the issue side hands to the store unit
// ----------------------------------------------------------
package lsu_pkg;

    // scoreboard transaction id
    localparam int trans_id_bits = 3;

    // store fault cause as defined by the privileged spec
    localparam logic [63:0] store_fault_cause = 64'd15;

    // ------------------------------------------------------------
    // operators
    // ------------------------------------------------------------
    // only traced, the byte enables already carry the size
    typedef enum logic [1:0] {
        SD,
        SW,
        SH,
        SB
    } fu_op;

    // ------------------------------------------------------------
    // exception record
    // ------------------------------------------------------------
    typedef struct packed {
        // trap cause
        logic [63:0] cause;
        // faulting virtual address
        logic [63:0] tval;
        logic        valid;
    } exception_t;

    // ------------------------------------------------------------
    // store request from issue
    // ------------------------------------------------------------
    typedef struct packed {
        fu_op                     operator;
        logic [trans_id_bits-1:0] trans_id;
        logic [63:0]              vaddr;
        // byte enables, already in doubleword lane order
        logic [7:0]               be;
        // data, lsb aligned, rotated by the store unit
        logic [63:0]              data;
    } store_req_t;

endpackage
